// File: bench/vmul_props.sv
// ==============================
// Stream and bus properties
// Bound into the accelerator top level
// ==============================
`timescale 1ns/1ps
`include "vmul_config.svh"

module vmul_props (
    input logic clk,
    input logic rst_n,
    input logic in_send,
    input logic res_valid_o,
    input logic res_credit_i,
    input logic wb_ack_o
);

    int held;
    int occupied;

    // Result credits held, and words between pipe entry and result port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held     <= `VMUL_RES_CREDITS;
            occupied <= 0;
        end else begin
            held     <= held + int'(res_credit_i) - int'(res_valid_o);
            occupied <= occupied + int'(in_send) - int'(res_valid_o);
        end
    end

    a_res_credit: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid_o |-> held > 0)
        else $error("Result sent with no credit held");

    a_occupancy: assert property (@(posedge clk) disable iff (!rst_n)
        occupied <= `VMUL_OUT_DEPTH)
        else $error("Pipeline plus output buffer exceed depth");

    // Single-cycle acknowledge
    a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack_o |=> !wb_ack_o)
        else $error("Bus acknowledge held for two cycles");

endmodule

bind vmul_top vmul_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_send      (in_send),
    .res_valid_o  (res_valid_o),
    .res_credit_i (res_credit_i),
    .wb_ack_o     (wb_ack_o)
);

// File: bench/vmul_tb.sv
// ==============================
// Vedic multiply accelerator testbench
// Table-driven streams, credit model, register checks
// ==============================
`timescale 1ns/1ps
`include "vmul_config.svh"

module vmul_tb;

    import vmul_pkg::*;

    localparam int NROWS  = 84;
    localparam int CLK_NS = 10;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        cmd_valid_i;
    logic [31:0] cmd_data_i;
    logic        cmd_credit_o;
    logic        res_valid_o;
    logic [31:0] res_data_o;
    logic        res_credit_i = 1'b0;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [7:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic        wb_ack_o;
    logic [31:0] wb_dat_o;

    // Stimulus table with expected value per row
    vmul_mode_e  mode_tab [NROWS];
    logic [15:0] coef_tab [NROWS];
    logic [31:0] cmd_tab  [NROWS];
    logic [31:0] exp_tab  [NROWS];
    int          n_rows = 0;

    // Credit model and scoreboard
    logic [31:0] exp_q [$];
    int          words_sent    = 0;
    int          credits_back  = 0;
    int          results_seen  = 0;
    int          credits_given = 0;
    bit          rx_hold       = 1'b0;
    bit          rx_random     = 1'b0;
    int          seed          = 50;
    int          err_count     = 0;
    vmul_mode_e  cur_mode      = VMUL_MODE_PAIR;
    logic [15:0] cur_coef      = '0;

    always #(CLK_NS / 2) clk = ~clk;

    vmul_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_data_i   (cmd_data_i),
        .cmd_credit_o (cmd_credit_o),
        .res_valid_o  (res_valid_o),
        .res_data_o   (res_data_o),
        .res_credit_i (res_credit_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_o     (wb_ack_o),
        .wb_dat_o     (wb_dat_o)
    );

    // ==============================
    // Table rows
    // ==============================
    task automatic pair_row(input logic [15:0] a, input logic [15:0] b);
        vmul_cmd_u c;
        c.pair.op_a      = a;
        c.pair.op_b      = b;
        mode_tab[n_rows] = VMUL_MODE_PAIR;
        coef_tab[n_rows] = '0;
        cmd_tab[n_rows]  = c;
        exp_tab[n_rows]  = 32'(a) * 32'(b);
        n_rows++;
    endtask

    task automatic scale_row(input logic [15:0] k, input logic [15:0] a,
                             input logic [15:0] off);
        vmul_cmd_u c;
        c.scale.offset   = off;
        c.scale.op_a     = a;
        mode_tab[n_rows] = VMUL_MODE_SCALE;
        coef_tab[n_rows] = k;
        cmd_tab[n_rows]  = c;
        exp_tab[n_rows]  = 32'(a) * 32'(k) + 32'(off);
        n_rows++;
    endtask

    // ==============================
    // Command side and bus
    // ==============================
    // Waits for a sender credit, then drives one word
    task automatic send_cmd(input int idx);
        @(posedge clk);
        while (`VMUL_IN_DEPTH + credits_back - words_sent <= 0) begin
            cmd_valid_i <= 1'b0;
            @(posedge clk);
        end
        exp_q.push_back(exp_tab[idx]);
        cmd_valid_i <= 1'b1;
        cmd_data_i  <= cmd_tab[idx];
        words_sent++;
    endtask

    // Waits until the pipe is empty and all receiver credits are back
    task automatic drain();
        @(posedge clk);
        cmd_valid_i <= 1'b0;
        @(negedge clk);
        while (exp_q.size() != 0 || results_seen != credits_given) begin
            @(negedge clk);
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [7:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= wdat;
        @(negedge clk);
        while (!wb_ack_o && waited < 8) begin
            waited++;
            @(negedge clk);
        end
        // Ack due one cycle after the request
        assert (wb_ack_o && waited == 1)
            else begin
                err_count++;
                $display("Bus acknowledge near %0t came late or not at all", $time);
            end
        rdat = wb_dat_o;
        @(posedge clk);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic check_reg(input logic [7:0] adr, input logic [31:0] expected);
        logic [31:0] rdat;
        bus_cycle(1'b0, adr, '0, rdat);
        assert (rdat == expected)
            else begin
                err_count++;
                $display("Mismatch at %0t: reg %h read %h, expected %h",
                         $time, adr, rdat, expected);
            end
    endtask

    // Mode or coefficient only change while empty
    task automatic apply_rows(input int first, input int last);
        logic [31:0] unused;
        for (int i = first; i < last; i++) begin
            if (mode_tab[i] != cur_mode || coef_tab[i] != cur_coef) begin
                drain();
                bus_cycle(1'b1, `VMUL_ADR_CTRL, {31'b0, mode_tab[i]}, unused);
                bus_cycle(1'b1, `VMUL_ADR_COEF, {16'b0, coef_tab[i]}, unused);
                cur_mode = mode_tab[i];
                cur_coef = coef_tab[i];
            end
            send_cmd(i);
        end
    endtask

    // ==============================
    // Result side
    // ==============================
    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (cmd_credit_o) begin
                credits_back++;
            end
            if (res_valid_o) begin
                results_seen++;
                assert (exp_q.size() != 0)
                    else begin
                        err_count++;
                        $display("Result %h at %0t arrived with nothing expected",
                                 res_data_o, $time);
                    end
                if (exp_q.size() != 0) begin
                    assert (res_data_o == exp_q[0])
                        else begin
                            err_count++;
                            $display("Mismatch at %0t: result %h, expected %h",
                                     $time, res_data_o, exp_q[0]);
                        end
                    void'(exp_q.pop_front());
                end
            end
        end
    end

    // Receiver hands back one credit per consumed result
    always @(posedge clk) begin
        bit pause;
        pause = 1'b0;
        if (rx_random) begin
            pause = ($random(seed) & 3) == 0;
        end
        if (rst_n && !rx_hold && !pause && results_seen > credits_given) begin
            res_credit_i <= 1'b1;
            credits_given++;
        end else begin
            res_credit_i <= 1'b0;
        end
    end

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        logic [31:0] r;
        logic [15:0] blk_coef;
        logic [31:0] unused;
        int          seen_before;
        rst_n       <= 1'b0;
        cmd_valid_i <= 1'b0;
        cmd_data_i  <= '0;
        wb_cyc_i    <= 1'b0;
        wb_stb_i    <= 1'b0;
        wb_we_i     <= 1'b0;
        wb_adr_i    <= '0;
        wb_dat_i    <= '0;

        // Edge products
        pair_row(16'h0000, 16'h0000);
        pair_row(16'hFFFF, 16'hFFFF);
        pair_row(16'h0001, 16'hFFFF);
        pair_row(16'h8000, 16'h0002);
        pair_row(16'hFFFF, 16'h0000);
        pair_row(16'h1234, 16'h5678);
        pair_row(16'h0100, 16'h0100);
        pair_row(16'h00FF, 16'hFF00);
        scale_row(16'h0003, 16'h0007, 16'h0005);
        scale_row(16'h0003, 16'h8000, 16'h00FF);
        scale_row(16'hFFFF, 16'hFFFF, 16'hFFFF);
        scale_row(16'hFFFF, 16'h0000, 16'h1234);
        // Back-pressure burst
        for (int i = 0; i < 8; i++) begin
            scale_row(16'hFFFF, 16'(i * 4099), 16'(i * 3));
        end
        // Random blocks with the mode flipping every 16 rows
        for (int i = 0; i < 64; i++) begin
            if (i % 16 == 0) begin
                r        = $random(seed);
                blk_coef = r[15:0];
            end
            r = $random(seed);
            if ((i / 16) % 2 == 0) begin
                pair_row(r[31:16], r[15:0]);
            end else begin
                scale_row(blk_coef, r[15:0], r[31:16]);
            end
        end

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        apply_rows(0, 12);
        drain();

        // Receiver withheld so only the reset credits may go out
        seen_before = results_seen;
        rx_hold     = 1'b1;
        apply_rows(12, 20);
        @(posedge clk);
        cmd_valid_i <= 1'b0;
        repeat (30) @(negedge clk);
        assert (results_seen - seen_before <= `VMUL_RES_CREDITS)
            else begin
                err_count++;
                $display("More results than receiver credits went out while held");
            end
        rx_hold = 1'b0;
        drain();

        rx_random = 1'b1;
        apply_rows(20, NROWS);
        drain();
        rx_random = 1'b0;

        assert (credits_back == words_sent && results_seen == NROWS)
            else begin
                err_count++;
                $display("Lost traffic: %0d sent, %0d credits back, %0d results",
                         words_sent, credits_back, results_seen);
            end

        // Register map, last stream block left the mode at scale
        bus_cycle(1'b1, `VMUL_ADR_CTRL, 32'h0000_0000, unused);
        check_reg(`VMUL_ADR_CTRL, 32'h0000_0000);
        bus_cycle(1'b1, `VMUL_ADR_COEF, 32'h1234_ABCD, unused);
        check_reg(`VMUL_ADR_COEF, 32'h0000_ABCD);
        bus_cycle(1'b1, `VMUL_ADR_ID, 32'h0, unused);
        check_reg(`VMUL_ADR_ID, `VMUL_ID_VALUE);
        check_reg(8'h10, `VMUL_UNMAPPED);
        check_reg(`VMUL_ADR_COUNT, 32'(results_seen));

        $display("Results checked: %0d, errors: %0d", results_seen, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog allows 40 cycles per row plus margin
    initial begin
        #(NROWS * 40 * CLK_NS + 2000);
        $display("Timeout at %0t, run did not complete", $time);
        $display("Something failed");
        $finish;
    end

endmodule

// File: hw/credit_fifo.sv
// ============================
// Credit-gated FIFO
// Sends the head entry while a credit is held
// ============================
`timescale 1ns/1ps
`include "vmul_config.svh"

module credit_fifo #(
    parameter int DEPTH   = 4,
    parameter int CREDITS = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push_i,
    input  logic [`VMUL_RES_W-1:0] push_data_i,
    input  logic                   credit_i,
    output logic                   send_o,
    output logic [`VMUL_RES_W-1:0] send_data_o,
    output logic                   freed_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(CREDITS + 1);

    logic [`VMUL_RES_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic [CRD_W-1:0]       credits;

    // Head leaves when present and paid for
    assign send_o      = (count != '0) && (credits != '0);
    assign send_data_o = mem[rd_ptr];
    // Departure doubles as a returned credit upstream
    assign freed_o     = send_o;

    // Storage, no reset
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CRD_W'(CREDITS);
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (send_o) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Occupancy
            case ({push_i, send_o})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Credit balance, one gained per pulse, one spent per send
            case ({credit_i, send_o})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// File: hw/vedic_mult_node.sv
// ============================
// Recursive Urdhva Tiryagbhyam multiplier
// Splits operands in halves down to a 2x2 cell
// ============================
`timescale 1ns/1ps

module vedic_mult_node #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]   a_i,
    input  logic [WIDTH-1:0]   b_i,
    output logic [2*WIDTH-1:0] p_o
);

    if (WIDTH == 2) begin : g_base
        // Base cell, vertical and crosswise bit products
        logic pp_ll, pp_hl, pp_lh, pp_hh;

        assign pp_ll = a_i[0] & b_i[0];
        assign pp_hl = a_i[1] & b_i[0];
        assign pp_lh = a_i[0] & b_i[1];
        assign pp_hh = a_i[1] & b_i[1];

        assign p_o[0] = pp_ll;
        assign p_o[1] = pp_hl ^ pp_lh;
        // Crosswise carry folds into the high column
        assign p_o[2] = pp_hh ^ (pp_hl & pp_lh);
        assign p_o[3] = pp_hh & pp_hl & pp_lh;
    end else begin : g_split
        localparam int H = WIDTH / 2;

        logic [WIDTH-1:0] q0, q1, q2, q3;
        logic [H+1:0]     sum1, sum2, sum3;

        // Vertical (lo*lo, hi*hi) and crosswise (hi*lo, lo*hi) products
        vedic_mult_node #(.WIDTH(H)) u_ll (.a_i(a_i[H-1:0]), .b_i(b_i[H-1:0]), .p_o(q0));
        vedic_mult_node #(.WIDTH(H)) u_hl (.a_i(a_i[WIDTH-1:H]), .b_i(b_i[H-1:0]), .p_o(q1));
        vedic_mult_node #(.WIDTH(H)) u_lh (.a_i(a_i[H-1:0]), .b_i(b_i[WIDTH-1:H]), .p_o(q2));
        vedic_mult_node #(.WIDTH(H)) u_hh (.a_i(a_i[WIDTH-1:H]), .b_i(b_i[WIDTH-1:H]), .p_o(q3));

        // Second column: upper q0 plus lower crosswise halves
        assign sum1 = {2'b00, q0[WIDTH-1:H]} + {2'b00, q1[H-1:0]} + {2'b00, q2[H-1:0]};
        // Third column: carry in, upper crosswise halves, lower q3
        assign sum2 = {{H{1'b0}}, sum1[H+1:H]} + {2'b00, q1[WIDTH-1:H]}
                    + {2'b00, q2[WIDTH-1:H]} + {2'b00, q3[H-1:0]};
        // Top column, product never overflows so the carry out drops
        assign sum3 = {2'b00, q3[WIDTH-1:H]} + {{H{1'b0}}, sum2[H+1:H]};

        assign p_o = {sum3[H-1:0], sum2[H-1:0], sum1[H-1:0], q0[H-1:0]};
    end

endmodule

// File: hw/vmul_config.svh
// ============================
// Vedic multiply accelerator configuration
// Widths, buffer depths, credit counts, register map
// ============================
`ifndef VMUL_CONFIG_SVH
`define VMUL_CONFIG_SVH

// Datapath widths
`define VMUL_OP_W        16
`define VMUL_RES_W       32

// Buffer depths
// Output depth is also the input FIFO's starting credit count
`define VMUL_IN_DEPTH    4
`define VMUL_OUT_DEPTH   4

// Credits held toward the result receiver after reset
`define VMUL_RES_CREDITS 2

// Register map, byte addresses
`define VMUL_ADR_CTRL    8'h00
`define VMUL_ADR_COEF    8'h04
`define VMUL_ADR_COUNT   8'h08
`define VMUL_ADR_ID      8'h0C

// Fixed read values
`define VMUL_ID_VALUE    32'h564D_0001
`define VMUL_UNMAPPED    32'hDEAD_BEEF

`endif

// File: hw/vmul_pipe.sv
// ============================
// Three-stage multiply pipeline
// Decode, four half-width Vedic products, combine and offset add
// ============================
`timescale 1ns/1ps
`include "vmul_config.svh"

module vmul_pipe (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid_i,
    input  vmul_pkg::vmul_cmd_u    in_data_i,
    input  vmul_pkg::vmul_mode_e   mode_i,
    input  logic [`VMUL_OP_W-1:0]  coef_i,
    output logic                   out_valid_o,
    output logic [`VMUL_RES_W-1:0] out_data_o
);

    import vmul_pkg::*;

    localparam int HALF = `VMUL_OP_W / 2;

    // Stage 1 registers
    logic                  s1_valid;
    logic [`VMUL_OP_W-1:0] s1_a;
    logic [`VMUL_OP_W-1:0] s1_b;
    logic [`VMUL_OP_W-1:0] s1_off;

    // Half-width products from stage 1 operands
    logic [`VMUL_OP_W-1:0] q0, q1, q2, q3;

    // Stage 2 registers
    logic                  s2_valid;
    logic [`VMUL_OP_W-1:0] s2_q0, s2_q1, s2_q2, s2_q3;
    logic [`VMUL_OP_W-1:0] s2_off;

    // Full product before offset
    logic [`VMUL_RES_W-1:0] prod;

    // ============================
    // Stage 1, decode and operand select
    // ============================
    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            if (mode_i == VMUL_MODE_SCALE) begin
                // Scale: operand times coefficient plus offset
                s1_a   <= in_data_i.scale.op_a;
                s1_b   <= coef_i;
                s1_off <= in_data_i.scale.offset;
            end else begin
                // Pair: plain product
                s1_a   <= in_data_i.pair.op_a;
                s1_b   <= in_data_i.pair.op_b;
                s1_off <= '0;
            end
        end
    end

    // ============================
    // Stage 2, registered 8x8 products
    // ============================
    vedic_mult_node #(.WIDTH(HALF)) u_mul_ll (
        .a_i(s1_a[HALF-1:0]), .b_i(s1_b[HALF-1:0]), .p_o(q0));
    vedic_mult_node #(.WIDTH(HALF)) u_mul_hl (
        .a_i(s1_a[`VMUL_OP_W-1:HALF]), .b_i(s1_b[HALF-1:0]), .p_o(q1));
    vedic_mult_node #(.WIDTH(HALF)) u_mul_lh (
        .a_i(s1_a[HALF-1:0]), .b_i(s1_b[`VMUL_OP_W-1:HALF]), .p_o(q2));
    vedic_mult_node #(.WIDTH(HALF)) u_mul_hh (
        .a_i(s1_a[`VMUL_OP_W-1:HALF]), .b_i(s1_b[`VMUL_OP_W-1:HALF]), .p_o(q3));

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_q0  <= q0;
            s2_q1  <= q1;
            s2_q2  <= q2;
            s2_q3  <= q3;
            s2_off <= s1_off;
        end
    end

    // ============================
    // Stage 3, combine and offset add
    // ============================
    // hi*hi and lo*lo never overlap, crosswise terms sit at HALF
    assign prod = {s2_q3, s2_q0}
                + {{HALF{1'b0}}, s2_q1, {HALF{1'b0}}}
                + {{HALF{1'b0}}, s2_q2, {HALF{1'b0}}};

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            out_data_o <= prod + {{(`VMUL_RES_W - `VMUL_OP_W){1'b0}}, s2_off};
        end
    end

    // Valid shift, push lands 3 cycles after input
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid    <= 1'b0;
            s2_valid    <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            s1_valid    <= in_valid_i;
            s2_valid    <= s1_valid;
            out_valid_o <= s2_valid;
        end
    end

endmodule

// File: hw/vmul_pkg.sv
// ============================
// Vedic multiply accelerator types
// Command word decodes and datapath mode
// ============================
`include "vmul_config.svh"

package vmul_pkg;

    // ============================
    // Datapath mode
    // ============================
    // Selected by CTRL bit 0
    typedef enum logic {
        VMUL_MODE_PAIR  = 1'b0,
        VMUL_MODE_SCALE = 1'b1
    } vmul_mode_e;

    // ============================
    // Command word
    // ============================
    // Same 32 bits, read through the view picked by mode
    typedef union packed {
        // Pair: a in upper half, b in lower half
        struct packed {
            logic [`VMUL_OP_W-1:0] op_a;
            logic [`VMUL_OP_W-1:0] op_b;
        } pair;
        // Scale: offset in upper half, a in lower half
        struct packed {
            logic [`VMUL_OP_W-1:0] offset;
            logic [`VMUL_OP_W-1:0] op_a;
        } scale;
    } vmul_cmd_u;

endpackage

// File: hw/vmul_regs.sv
// ============================
// Wishbone-style register block
// Mode, coefficient, result count, identity
// ============================
`timescale 1ns/1ps
`include "vmul_config.svh"

module vmul_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [7:0]            wb_adr_i,
    input  logic [31:0]           wb_dat_i,
    output logic                  wb_ack_o,
    output logic [31:0]           wb_dat_o,
    input  logic                  res_sent_i,
    output vmul_pkg::vmul_mode_e  mode_o,
    output logic [`VMUL_OP_W-1:0] coef_o
);

    import vmul_pkg::*;

    logic        req;
    logic [31:0] count_q;
    logic [31:0] rd_data;

    // New request only while no ack is pending
    assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

    // ============================
    // Read decode
    // ============================
    always_comb begin
        case (wb_adr_i)
            `VMUL_ADR_CTRL:  rd_data = {31'b0, mode_o};
            `VMUL_ADR_COEF:  rd_data = {{(32 - `VMUL_OP_W){1'b0}}, coef_o};
            `VMUL_ADR_COUNT: rd_data = count_q;
            `VMUL_ADR_ID:    rd_data = `VMUL_ID_VALUE;
            default:         rd_data = `VMUL_UNMAPPED;
        endcase
    end

    // Read data rides with the ack
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_o <= rd_data;
        end
    end

    // ============================
    // Control state
    // ============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack_o <= 1'b0;
            mode_o   <= VMUL_MODE_PAIR;
            coef_o   <= '0;
            count_q  <= '0;
        end else begin
            // Single-cycle ack, one cycle after request
            wb_ack_o <= req;
            // Only CTRL and COEF take writes
            if (req && wb_we_i) begin
                case (wb_adr_i)
                    `VMUL_ADR_CTRL: mode_o <= vmul_mode_e'(wb_dat_i[0]);
                    `VMUL_ADR_COEF: coef_o <= wb_dat_i[`VMUL_OP_W-1:0];
                    default:        ;
                endcase
            end
            // Delivered results, wraps
            if (res_sent_i) begin
                count_q <= count_q + 32'd1;
            end
        end
    end

endmodule

// File: hw/vmul_top.sv
// ============================
// Streaming Vedic multiply accelerator
// Input buffer, pipeline, output buffer, registers
// ============================
`timescale 1ns/1ps
`include "vmul_config.svh"

module vmul_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // Command stream
    input  logic                   cmd_valid_i,
    input  logic [`VMUL_RES_W-1:0] cmd_data_i,
    output logic                   cmd_credit_o,
    // Result stream
    output logic                   res_valid_o,
    output logic [`VMUL_RES_W-1:0] res_data_o,
    input  logic                   res_credit_i,
    // Register bus
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [7:0]             wb_adr_i,
    input  logic [31:0]            wb_dat_i,
    output logic                   wb_ack_o,
    output logic [31:0]            wb_dat_o
);

    import vmul_pkg::*;

    // Input buffer to pipeline
    logic                   in_send;
    logic [`VMUL_RES_W-1:0] in_data;
    // Pipeline to output buffer
    logic                   pipe_valid;
    logic [`VMUL_RES_W-1:0] pipe_data;
    // Output departures return as input credits
    logic                   out_freed;
    // Register steering
    vmul_mode_e             mode;
    logic [`VMUL_OP_W-1:0]  coef;

    // Starts with output depth credits, so the pipe never overruns out_fifo
    credit_fifo #(
        .DEPTH   (`VMUL_IN_DEPTH),
        .CREDITS (`VMUL_OUT_DEPTH)
    ) in_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (cmd_valid_i),
        .push_data_i (cmd_data_i),
        .credit_i    (out_freed),
        .send_o      (in_send),
        .send_data_o (in_data),
        .freed_o     (cmd_credit_o)
    );

    vmul_pipe u_pipe (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (in_send),
        .in_data_i   (in_data),
        .mode_i      (mode),
        .coef_i      (coef),
        .out_valid_o (pipe_valid),
        .out_data_o  (pipe_data)
    );

    // Credits here come from the downstream receiver
    credit_fifo #(
        .DEPTH   (`VMUL_OUT_DEPTH),
        .CREDITS (`VMUL_RES_CREDITS)
    ) out_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (pipe_valid),
        .push_data_i (pipe_data),
        .credit_i    (res_credit_i),
        .send_o      (res_valid_o),
        .send_data_o (res_data_o),
        .freed_o     (out_freed)
    );

    vmul_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_ack_o   (wb_ack_o),
        .wb_dat_o   (wb_dat_o),
        .res_sent_i (res_valid_o),
        .mode_o     (mode),
        .coef_o     (coef)
    );

endmodule

// File: list.f
+incdir+hw
hw/vmul_pkg.sv
hw/vedic_mult_node.sv
hw/credit_fifo.sv
hw/vmul_pipe.sv
hw/vmul_regs.sv
hw/vmul_top.sv
bench/vmul_props.sv
bench/vmul_tb.sv
